// ==== verilog/usb_stream_params.svh ====
`ifndef USB_STREAM_PARAMS_SVH
`define USB_STREAM_PARAMS_SVH

// ==========================================================
// Datapath sizes
// ==========================================================
`define FIFO_DEPTH     1024        // Bytes of FIFO storage
`define LEVEL_W        11          // Holds 0..FIFO_DEPTH
`define PKT_LEN_W      12          // Same width as USB txdat_len
`define PKT_LEN_RESET  512         // One HS bulk packet
`define CNT_W          16          // Event counters, wrapping

// ==========================================================
// Status LED
// ==========================================================
`define HEARTBEAT_HALF 30_000_000  // Half a second at 60 MHz

// ==========================================================
// APB register offsets
// ==========================================================
`define REG_CTRL       8'h00       // Bit 0 enable
`define REG_PKT_LEN    8'h04       // Bytes per packet
`define REG_STATUS     8'h08       // Level and link state
`define REG_PKT_CNT    8'h0C       // Packets sent
`define REG_DROP_CNT   8'h10       // Pixels dropped

`endif

// ==== verilog/stream_types_pkg.sv ====
`include "usb_stream_params.svh"

package stream_types_pkg;

  // ==========================================================
  // Datapath vectors
  // ==========================================================
  typedef logic [15:0] pixel_t;                  // Camera pixel, RGB565
  typedef logic [7:0]  byte_t;                   // One USB byte

  // Byte count held in the FIFO
  typedef logic [`LEVEL_W-1:0] fifo_level_t;

  // Bulk packet length, as given to the controller
  typedef logic [`PKT_LEN_W-1:0] pkt_len_t;

  typedef logic [`CNT_W-1:0] cnt_t;              // Wrapping event counter

  // ==========================================================
  // Packet FSM
  // ==========================================================
  typedef enum logic {
    PKT_IDLE = 1'b0,                             // Waiting for a full packet
    PKT_SEND = 1'b1                              // Offering bytes to USB
  } pkt_state_e;

endpackage

// ==== verilog/apb_map_pkg.sv ====
package apb_map_pkg;

  // ==========================================================
  // APB register bus
  // ==========================================================

  // Byte address within the block
  typedef logic [7:0]  apb_addr_t;

  // Read and write data words
  typedef logic [31:0] apb_data_t;

endpackage

// ==== verilog/apb_regs.sv ====
`include "usb_stream_params.svh"

module apb_regs
  import stream_types_pkg::*;
  import apb_map_pkg::*;
(
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_addr_t   paddr_i,
  input  apb_data_t   pwdata_i,
  input  fifo_level_t level_i,                   // From FIFO
  input  logic        usb_online_i,
  input  logic        usb_suspend_i,
  input  logic        pkt_done_i,                // One pulse per finished packet
  input  logic        drop_i,                    // One pulse per refused pixel
  output apb_data_t   prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        enable_o,
  output pkt_len_t    pkt_len_o
);

  localparam int STAT_ONLINE_BIT  = 16;
  localparam int STAT_SUSPEND_BIT = 17;

  logic      access;                             // APB access phase
  logic      wr_en;
  logic      reg_hit;                            // Address is mapped
  logic      enable_q;
  pkt_len_t  pkt_len_q;
  cnt_t      pkt_cnt_q;
  cnt_t      drop_cnt_q;
  apb_data_t status_word;

  assign access   = psel_i && penable_i;
  assign wr_en    = access && pwrite_i;
  assign pready_o = 1'b1;                        // No wait states

  // ==========================================================
  // Read decode
  // ==========================================================
  always_comb begin
    status_word = '0;
    status_word[`LEVEL_W-1:0]     = level_i;
    status_word[STAT_ONLINE_BIT]  = usb_online_i;
    status_word[STAT_SUSPEND_BIT] = usb_suspend_i;
  end

  always_comb begin
    reg_hit  = 1'b1;
    prdata_o = '0;                               // Unmapped reads as zero
    case (paddr_i)
      `REG_CTRL:     prdata_o = apb_data_t'(enable_q);
      `REG_PKT_LEN:  prdata_o = apb_data_t'(pkt_len_q);
      `REG_STATUS:   prdata_o = status_word;
      `REG_PKT_CNT:  prdata_o = apb_data_t'(pkt_cnt_q);
      `REG_DROP_CNT: prdata_o = apb_data_t'(drop_cnt_q);
      default:       reg_hit  = 1'b0;
    endcase
  end

  assign pslverr_o = access && !reg_hit;         // Only during the access phase

  // ==========================================================
  // Writable registers
  // ==========================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      enable_q  <= 1'b0;
      pkt_len_q <= pkt_len_t'(`PKT_LEN_RESET);
    end else if (wr_en) begin
      case (paddr_i)
        `REG_CTRL:    enable_q  <= pwdata_i[0];
        `REG_PKT_LEN: pkt_len_q <= pwdata_i[`PKT_LEN_W-1:0];  // Range checked downstream
        default:      ;                          // Read-only or unmapped
      endcase
    end
  end

  // Event counters, free wrapping
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      pkt_cnt_q  <= '0;
      drop_cnt_q <= '0;
    end else begin
      if (pkt_done_i) pkt_cnt_q  <= pkt_cnt_q + 1'b1;
      if (drop_i)     drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign enable_o  = enable_q;
  assign pkt_len_o = pkt_len_q;

endmodule

// ==== verilog/pixel_fifo.sv ====
`include "usb_stream_params.svh"

module pixel_fifo
  import stream_types_pkg::*;
(
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  logic        pix_valid_i,               // No ready, refused pixels drop
  input  pixel_t      pix_data_i,
  input  logic        rd_en_i,                   // Pop head byte
  output byte_t       head_o,                    // First word fall through
  output fifo_level_t level_o,                   // Bytes held
  output logic        drop_o
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  byte_t             mem [`FIFO_DEPTH];          // Byte-wide ring
  logic [PTR_W-1:0]  wr_ptr_q;                   // Always even
  logic [PTR_W-1:0]  rd_ptr_q;
  fifo_level_t       level_q;
  logic              accept;

  // ==========================================================
  // Acceptance
  // ==========================================================
  // Two free bytes needed, a pop on the same edge is not counted
  assign accept = pix_valid_i && (level_q <= fifo_level_t'(`FIFO_DEPTH - 2));
  assign drop_o = pix_valid_i && !accept;        // Counted in DROP_CNT

  // ==========================================================
  // Storage
  // ==========================================================
  always_ff @(posedge ulpi_clk) begin
    if (accept) begin
      mem[wr_ptr_q]        <= pix_data_i[7:0];   // Low byte goes out first
      mem[wr_ptr_q + 1'b1] <= pix_data_i[15:8];
    end
  end

  assign head_o = mem[rd_ptr_q];                 // Valid whenever level is nonzero

  // ==========================================================
  // Pointers and level
  // ==========================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (accept)  wr_ptr_q <= wr_ptr_q + 2'd2;  // Wraps at FIFO_DEPTH
      if (rd_en_i) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      level_q <= '0;
    end else begin
      case ({accept, rd_en_i})
        2'b10:   level_q <= level_q + fifo_level_t'(2);  // Pixel in
        2'b01:   level_q <= level_q - fifo_level_t'(1);  // Byte out
        2'b11:   level_q <= level_q + fifo_level_t'(1);  // Both
        default: level_q <= level_q;
      endcase
    end
  end

  assign level_o = level_q;

endmodule

// ==== verilog/packet_ctrl.sv ====
`include "usb_stream_params.svh"

module packet_ctrl
  import stream_types_pkg::*;
(
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  logic        enable_i,                  // CTRL bit 0
  input  pkt_len_t    pkt_len_i,                 // PKT_LEN register
  input  fifo_level_t level_i,                   // Bytes queued
  input  logic        usb_online_i,
  input  logic        usb_suspend_i,
  input  logic        usb_reset_i,
  input  logic        usb_txpop_i,               // Controller takes a byte
  output logic        rd_en_o,                   // FIFO pop
  output logic        pkt_done_o,                // Last byte of a packet
  output logic        usb_txval_o,
  output logic        usb_txcork_o
);

  pkt_state_e state_q;
  pkt_len_t   byte_cnt_q;                        // Bytes popped this packet
  logic       link_ok;
  logic       len_ok;
  logic       level_ok;
  logic       start;
  logic       last_pop;

  // ==========================================================
  // Start and abort conditions
  // ==========================================================
  assign link_ok  = usb_online_i && !usb_suspend_i && !usb_reset_i;
  assign len_ok   = (pkt_len_i != '0) && (pkt_len_i <= pkt_len_t'(`FIFO_DEPTH));
  assign level_ok = pkt_len_t'(level_i) >= pkt_len_i;  // Whole packet queued
  assign start    = enable_i && link_ok && len_ok && level_ok;

  assign rd_en_o  = (state_q == PKT_SEND) && usb_txpop_i;  // Never empty in SEND
  assign last_pop = (byte_cnt_q + pkt_len_t'(1)) >= pkt_len_i;
  assign pkt_done_o = rd_en_o && last_pop;

  // ==========================================================
  // Packet FSM
  // ==========================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q    <= PKT_IDLE;
      byte_cnt_q <= '0;
    end else begin
      case (state_q)
        PKT_IDLE: begin
          byte_cnt_q <= '0;
          if (start) state_q <= PKT_SEND;
        end
        PKT_SEND: begin
          if (!link_ok) begin
            state_q    <= PKT_IDLE;              // Abandon, rest stays queued
            byte_cnt_q <= '0;
          end else if (pkt_done_o) begin
            state_q    <= PKT_IDLE;
            byte_cnt_q <= '0;
          end else if (rd_en_o) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
        end
        default: state_q <= PKT_IDLE;
      endcase
    end
  end

  assign usb_txval_o  = (state_q == PKT_SEND);
  assign usb_txcork_o = (state_q != PKT_SEND);   // Hold off the IN token

endmodule

// ==== verilog/status_led.sv ====
`include "usb_stream_params.svh"

module status_led #(
  parameter int unsigned HALF_PERIOD = `HEARTBEAT_HALF  // Cycles per toggle
) (
  input  logic       ulpi_clk,
  input  logic       I_rst_n,
  input  logic       usb_online_i,
  input  logic       usb_suspend_i,
  input  logic       usb_reset_i,
  output logic [3:0] led_o                       // Active low except heartbeat
);

  localparam int DIV_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

  logic [DIV_W-1:0] div_q;                       // Heartbeat divider
  logic             beat_q;

  // ==========================================================
  // Heartbeat
  // ==========================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      div_q  <= '0;
      beat_q <= 1'b0;
    end else if (div_q == DIV_W'(HALF_PERIOD - 1)) begin
      div_q  <= '0;
      beat_q <= ~beat_q;                         // Once per half period
    end else begin
      div_q  <= div_q + 1'b1;
    end
  end

  assign led_o[0] = ~usb_online_i;               // Lit when connected
  assign led_o[1] = ~usb_reset_i;
  assign led_o[2] = ~usb_suspend_i;
  assign led_o[3] = beat_q;

endmodule

// ==== verilog/usb_stream_top.sv ====
`include "usb_stream_params.svh"

module usb_stream_top
  import stream_types_pkg::*;
  import apb_map_pkg::*;
#(
  parameter int unsigned HALF_PERIOD = `HEARTBEAT_HALF
) (
  input  logic       ulpi_clk,                   // 60 MHz from the PHY
  input  logic       I_rst_n,
  // APB slave
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  // Camera pixels, already in ulpi_clk domain
  input  logic       pix_valid_i,
  input  pixel_t     pix_data_i,
  // USB device controller
  input  logic       usb_online_i,
  input  logic       usb_suspend_i,
  input  logic       usb_reset_i,
  input  logic       usb_txpop_i,
  output logic       usb_txval_o,
  output logic       usb_txcork_o,
  output byte_t      usb_txdat_o,
  output pkt_len_t   usb_txdat_len_o,
  // Board LEDs
  output logic [3:0] led_o
);

  fifo_level_t level;                            // FIFO fill in bytes
  pkt_len_t    pkt_len;
  logic        enable;
  logic        rd_en;
  logic        pkt_done;
  logic        drop;

  assign usb_txdat_len_o = pkt_len;              // Controller sees PKT_LEN

  // ==========================================================
  // Registers
  // ==========================================================
  apb_regs u_apb_regs (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .level_i       (level),
    .usb_online_i  (usb_online_i),
    .usb_suspend_i (usb_suspend_i),
    .pkt_done_i    (pkt_done),
    .drop_i        (drop),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .enable_o      (enable),
    .pkt_len_o     (pkt_len)
  );

  // ==========================================================
  // Datapath and packet control
  // ==========================================================
  pixel_fifo u_pixel_fifo (
    .ulpi_clk    (ulpi_clk),
    .I_rst_n     (I_rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_data_i  (pix_data_i),
    .rd_en_i     (rd_en),
    .head_o      (usb_txdat_o),                  // Head byte straight to USB
    .level_o     (level),
    .drop_o      (drop)
  );

  packet_ctrl u_packet_ctrl (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .enable_i      (enable),
    .pkt_len_i     (pkt_len),
    .level_i       (level),
    .usb_online_i  (usb_online_i),
    .usb_suspend_i (usb_suspend_i),
    .usb_reset_i   (usb_reset_i),
    .usb_txpop_i   (usb_txpop_i),
    .rd_en_o       (rd_en),
    .pkt_done_o    (pkt_done),
    .usb_txval_o   (usb_txval_o),
    .usb_txcork_o  (usb_txcork_o)
  );

  status_led #(
    .HALF_PERIOD (HALF_PERIOD)
  ) u_status_led (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .usb_online_i  (usb_online_i),
    .usb_suspend_i (usb_suspend_i),
    .usb_reset_i   (usb_reset_i),
    .led_o         (led_o)
  );

endmodule

// ==== test/usb_stream_props.sv ====
`include "usb_stream_params.svh"

module usb_stream_props
  import stream_types_pkg::*;
(
  input logic        ulpi_clk,
  input logic        I_rst_n,
  input logic        rd_en_i,                    // FIFO pop
  input fifo_level_t level_i,                    // Same net as the FIFO level
  input pkt_len_t    pkt_len_i,                  // PKT_LEN register
  input logic        txval_i
);

  int fail_cnt;                                  // Assertion failures so far

  // ==========================================================
  // FIFO rules
  // ==========================================================
  a_pop_not_empty: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n) rd_en_i |-> (level_i != '0)
  ) else begin
    $error("FIFO pop with zero level");
    fail_cnt++;
  end

  a_level_max: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n) level_i <= fifo_level_t'(`FIFO_DEPTH)
  ) else begin
    $error("FIFO level above depth: %0d", level_i);
    fail_cnt++;
  end

  // ==========================================================
  // Packet rules
  // ==========================================================
  a_start_full: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
      $rose(txval_i) |-> (pkt_len_t'($past(level_i)) >= $past(pkt_len_i))
  ) else begin
    $error("Packet offered with fewer than PKT_LEN bytes queued");
    fail_cnt++;
  end

endmodule

bind packet_ctrl usb_stream_props u_props (
  .ulpi_clk  (ulpi_clk),
  .I_rst_n   (I_rst_n),
  .rd_en_i   (rd_en_o),
  .level_i   (level_i),
  .pkt_len_i (pkt_len_i),
  .txval_i   (usb_txval_o)
);

// ==== test/tb_usb_stream.sv ====
`include "usb_stream_params.svh"

module tb_usb_stream
  import stream_types_pkg::*;
  import apb_map_pkg::*;
();

  localparam int HALF = 20;                      // Short heartbeat for simulation
  localparam int T_REGS = 80;                    // Rough cycles per test
  localparam int T_DELIVERY = 100;
  localparam int T_GATING = 120;
  localparam int T_OVERFLOW = 1700;
  localparam int T_ABORT = 150;
  localparam int T_BEAT = 100;
  localparam int WATCHDOG_CYCLES =
    2 * (T_REGS + T_DELIVERY + T_GATING + T_OVERFLOW + T_ABORT + T_BEAT);

  // Named after the DUT ports so .* binds them
  logic       ulpi_clk = 1'b0;
  logic       I_rst_n;
  logic       psel_i, penable_i, pwrite_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i, prdata_o;
  logic       pready_o, pslverr_o;
  logic       pix_valid_i;
  pixel_t     pix_data_i;
  logic       usb_online_i, usb_suspend_i, usb_reset_i, usb_txpop_i;
  logic       usb_txval_o, usb_txcork_o;
  byte_t      usb_txdat_o;
  pkt_len_t   usb_txdat_len_o;
  logic [3:0] led_o;

  byte_t       model_q[$];                       // Bytes expected at the FIFO head
  int          exp_drops;
  int          exp_pkts;
  int          errs;
  int          checks;
  logic        last_slverr;
  logic [31:0] lfsr;

  usb_stream_top #(.HALF_PERIOD(HALF)) u_usb_stream_top (.*);

  always #5 ulpi_clk = ~ulpi_clk;                // 10 unit period

  // ==========================================================
  // Checking and stimulus helpers
  // ==========================================================
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      errs++;
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic apb_data_t expected_status(input int level);
    apb_data_t w;
    w     = '0;
    w[10:0] = level[10:0];
    w[16] = usb_online_i;
    w[17] = usb_suspend_i;
    return w;
  endfunction

  task automatic apb_access(input logic write, input apb_addr_t addr,
                            input apb_data_t wdata, output apb_data_t rdata);
    @(posedge ulpi_clk);                         // Setup phase
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge ulpi_clk);
    penable_i <= 1'b1;                           // Access phase
    @(negedge ulpi_clk);
    rdata       = prdata_o;
    last_slverr = pslverr_o;
    @(posedge ulpi_clk);                         // Write lands here
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input apb_addr_t addr, input string name, input apb_data_t exp);
    apb_data_t data;
    apb_access(1'b0, addr, '0, data);
    check(name, exp, data);
  endtask

  task automatic push_pixels(input int n);
    pixel_t pix;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < 16; b++) begin
        lfsr   = lfsr_next(lfsr);                // One step per bit
        pix[b] = lfsr[0];
      end
      @(posedge ulpi_clk);
      pix_valid_i <= 1'b1;
      pix_data_i  <= pix;
      if (`FIFO_DEPTH - model_q.size() >= 2) begin
        model_q.push_back(pix[7:0]);             // Low byte leaves first
        model_q.push_back(pix[15:8]);
      end else begin
        exp_drops++;
      end
    end
    @(posedge ulpi_clk);
    pix_valid_i <= 1'b0;
  endtask

  task automatic pop_bytes(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge ulpi_clk);
      usb_txpop_i <= 1'b1;
      @(negedge ulpi_clk);
      check("usb_txval_o", 1, usb_txval_o);
      check("usb_txcork_o", 0, usb_txcork_o);
      check("usb_txdat_o", model_q[0], usb_txdat_o);
      void'(model_q.pop_front());
    end
    @(posedge ulpi_clk);                         // Last byte taken here
    usb_txpop_i <= 1'b0;
  endtask

  task automatic wait_txval();
    int n;
    n = 0;
    do begin
      @(negedge ulpi_clk);
      n++;
    end while (usb_txval_o !== 1'b1 && n < 20);
    if (usb_txval_o !== 1'b1) begin
      $display("%0t: usb_txval_o never rose with a full packet queued", $time);
      errs++;
    end
  endtask

  task automatic expect_no_packet(input int n);
    repeat (n) begin
      @(negedge ulpi_clk);
      check("usb_txval_o", 0, usb_txval_o);
    end
  endtask

  task automatic beat_interval(output int n);
    logic prev;
    prev = led_o[3];                             // Called at a falling edge
    n    = 0;
    do begin
      @(negedge ulpi_clk);
      n++;
    end while (led_o[3] === prev && n < 4 * HALF);
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic reset_and_regs();
    @(negedge ulpi_clk);
    check("led_o", 4'b0110, led_o);              // Online, no reset, no suspend, beat low
    check("usb_txval_o", 0, usb_txval_o);
    check("usb_txcork_o", 1, usb_txcork_o);
    check("pslverr_o", 0, pslverr_o);
    check("pready_o", 1, pready_o);
    apb_read(`REG_CTRL, "CTRL", 0);
    apb_read(`REG_PKT_LEN, "PKT_LEN", 512);
    apb_read(`REG_STATUS, "STATUS", expected_status(0));
    apb_write(`REG_CTRL, 1);
    apb_read(`REG_CTRL, "CTRL", 1);
    apb_write(`REG_PKT_LEN, 16);
    apb_read(`REG_PKT_LEN, "PKT_LEN", 16);
    check("usb_txdat_len_o", 16, usb_txdat_len_o);
    apb_write(8'h14, 32'hFFFF_FFFF);             // Unmapped
    check("pslverr_o", 1, last_slverr);
    apb_read(8'h14, "unmapped read", 0);
    check("pslverr_o", 1, last_slverr);
  endtask

  task automatic packet_delivery();
    push_pixels(8);
    wait_txval();
    pop_bytes(16);
    exp_pkts++;
    @(negedge ulpi_clk);
    check("usb_txval_o", 0, usb_txval_o);
    apb_read(`REG_PKT_CNT, "PKT_CNT", exp_pkts);
    apb_read(`REG_STATUS, "STATUS", expected_status(model_q.size()));
  endtask

  task automatic threshold_gating();
    push_pixels(7);                              // One pixel short
    expect_no_packet(4);
    @(posedge ulpi_clk);
    usb_suspend_i <= 1'b1;
    push_pixels(1);
    expect_no_packet(4);
    check("led_o[2]", 0, led_o[2]);
    apb_read(`REG_STATUS, "STATUS", expected_status(model_q.size()));
    @(posedge ulpi_clk);
    usb_suspend_i <= 1'b0;
    wait_txval();
    pop_bytes(16);
    exp_pkts++;
  endtask

  task automatic overflow_drops();
    apb_write(`REG_CTRL, 0);                     // Hold packets off while filling
    push_pixels(520);
    expect_no_packet(2);
    apb_read(`REG_STATUS, "STATUS", expected_status(model_q.size()));
    apb_read(`REG_DROP_CNT, "DROP_CNT", exp_drops);
    apb_write(`REG_PKT_LEN, `FIFO_DEPTH);        // Drain as one full packet
    apb_write(`REG_CTRL, 1);
    wait_txval();
    pop_bytes(`FIFO_DEPTH);
    exp_pkts++;
    apb_write(`REG_PKT_LEN, 16);
    apb_read(`REG_PKT_CNT, "PKT_CNT", exp_pkts);
  endtask

  task automatic abort_and_resume();
    push_pixels(8);
    wait_txval();
    pop_bytes(5);
    usb_online_i <= 1'b0;                        // Link lost mid packet
    repeat (2) @(negedge ulpi_clk);
    check("usb_txval_o", 0, usb_txval_o);
    check("led_o[0]", 1, led_o[0]);
    apb_read(`REG_PKT_CNT, "PKT_CNT", exp_pkts);
    @(posedge ulpi_clk);
    usb_online_i <= 1'b1;
    push_pixels(3);                              // 11 left, top up past 16
    wait_txval();
    pop_bytes(16);
    exp_pkts++;
    apb_read(`REG_PKT_CNT, "PKT_CNT", exp_pkts);
  endtask

  task automatic heartbeat_period();
    int n;
    @(negedge ulpi_clk);
    beat_interval(n);                            // Partial, aligns to a toggle
    beat_interval(n);
    check("led_o[3] half period", HALF, n);
    beat_interval(n);
    check("led_o[3] half period", HALF, n);
  endtask

  // ==========================================================
  // Sequence and watchdog
  // ==========================================================
  initial begin
    I_rst_n       = 1'b0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    paddr_i       = '0;
    pwdata_i      = '0;
    pix_valid_i   = 1'b0;
    pix_data_i    = '0;
    usb_online_i  = 1'b1;
    usb_suspend_i = 1'b0;
    usb_reset_i   = 1'b0;
    usb_txpop_i   = 1'b0;
    lfsr          = 32'hef8c1a1f;
    repeat (5) @(posedge ulpi_clk);
    I_rst_n <= 1'b1;
    reset_and_regs();
    packet_delivery();
    threshold_gating();
    overflow_drops();
    abort_and_resume();
    heartbeat_period();
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errs, u_usb_stream_top.u_packet_ctrl.u_props.fail_cnt);
    if (errs == 0 && u_usb_stream_top.u_packet_ctrl.u_props.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ulpi_clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/stream_types_pkg.sv
verilog/apb_map_pkg.sv
verilog/apb_regs.sv
verilog/pixel_fifo.sv
verilog/packet_ctrl.sv
verilog/status_led.sv
verilog/usb_stream_top.sv
test/usb_stream_props.sv
test/tb_usb_stream.sv

// ==== Bender.yml ====
package:
  name: usb_stream

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stream_types_pkg.sv
      - verilog/apb_map_pkg.sv
      - verilog/apb_regs.sv
      - verilog/pixel_fifo.sv
      - verilog/packet_ctrl.sv
      - verilog/status_led.sv
      - verilog/usb_stream_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/usb_stream_props.sv
      - test/tb_usb_stream.sv
